/* Makefile */
VERILATOR       ?= verilator
TOP             ?= tb_sha512
FILELIST        ?= sim.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/sha512_params.svh */
`ifndef SHA512_PARAMS_SVH
`define SHA512_PARAMS_SVH

`define SHA512_DATA_W       32
`define SHA512_ADDR_W       8
`define SHA512_CORE_NAME    32'h73686135

`define SHA512_ADDR_NAME     8'h00
`define SHA512_ADDR_CTRL     8'h01
`define SHA512_ADDR_STATUS   8'h02
`define SHA512_ADDR_INTR_STS 8'h03
`define SHA512_ADDR_INTR_EN  8'h04
`define SHA512_ADDR_BLOCK    8'h20
`define SHA512_ADDR_DIGEST   8'h40
`endif

/* rtl/sha512.sv */
`timescale 1ns/1ns

module sha512 (
  input  logic                   clk,
  input  logic                   reset_n,
  input  sha512_reg_pkg::wb_req_t wb_req,
  output sha512_reg_pkg::wb_rsp_t wb_rsp,
  output logic                   notif_intr
);
  import sha512_reg_pkg::*;
  import sha512_core_pkg::*;

  // Register block to core
  sha512_ctrl_t   ctrl;
  logic [1023:0]  block;
  // Core back to register block
  sha512_status_t status;
  logic [511:0]   digest;

  sha512_regs u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .ctrl       (ctrl),
    .block      (block),
    .status     (status),
    .digest     (digest),
    .notif_intr (notif_intr)
  );

  sha512_core u_core (
    .clk     (clk),
    .reset_n (reset_n),
    .ctrl    (ctrl),
    .block   (block),
    .status  (status),
    .digest  (digest)
  );

endmodule

/* rtl/sha512_core.sv */
`timescale 1ns/1ns

module sha512_core (
  input  logic                          clk,
  input  logic                          reset_n,
  input  sha512_reg_pkg::sha512_ctrl_t   ctrl,
  input  logic [1023:0]                 block,
  output sha512_core_pkg::sha512_status_t status,
  output logic [511:0]                  digest
);
  import sha512_core_pkg::*;

  localparam logic [6:0] last_round = 7'd79;

  sha512_state_e     state_q;
  logic [6:0]        round_q;
  logic              valid_q;
  logic              start;
  // Index 0 is H0 / a / W_t, so the packed vectors read big-endian
  logic [0:7][63:0]  h_q;
  logic [0:7][63:0]  v_q;
  logic [0:15][63:0] w_q;
  logic [0:7][63:0]  iv;
  logic [63:0]       k_t;
  logic [63:0]       t1;
  logic [63:0]       t2;
  logic [63:0]       w_new;

  function automatic logic [63:0] rotr(input logic [63:0] x, input int unsigned n);
    return (x >> n) | (x << (64 - n));
  endfunction

  sha512_k_rom u_k_rom (
    .round (round_q),
    .k     (k_t)
  );

  // --------------------
  // Initial hash values per mode
  always_comb begin
    case (ctrl.mode)
      mode_224: iv = {64'h8c3d37c819544da2, 64'h73e1996689dcd4d6, 64'h1dfab7ae32ff9c82,
                      64'h679dd514582f9fcf, 64'h0f6d2b697bd44da8, 64'h77e36f7304c48942,
                      64'h3f9d85a86a1d36c8, 64'h1112e6ad91d692a1};
      mode_256: iv = {64'h22312194fc2bf72c, 64'h9f555fa3c84c64c2, 64'h2393b86b6f53b151,
                      64'h963877195940eabd, 64'h96283ee2a88effe3, 64'hbe5e1e2553863992,
                      64'h2b0199fc2c85b8aa, 64'h0eb72ddc81c52ca2};
      mode_384: iv = {64'hcbbb9d5dc1059ed8, 64'h629a292a367cd507, 64'h9159015a3070dd17,
                      64'h152fecd8f70e5939, 64'h67332667ffc00b31, 64'h8eb44a8768581511,
                      64'hdb0c2e0d64f98fa7, 64'h47b5481dbefa4fa4};
      default:  iv = {64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b,
                      64'ha54ff53a5f1d36f1, 64'h510e527fade682d1, 64'h9b05688c2b3e6c1f,
                      64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179};
    endcase
  end

  // --------------------
  // Round datapath
  always_comb begin
    // T1 from e, f, g, h, K_t, W_t
    t1 = v_q[7] + (rotr(v_q[4], 14) ^ rotr(v_q[4], 18) ^ rotr(v_q[4], 41))
       + ((v_q[4] & v_q[5]) ^ (~v_q[4] & v_q[6])) + k_t + w_q[0];
    // T2 from a, b, c
    t2 = (rotr(v_q[0], 28) ^ rotr(v_q[0], 34) ^ rotr(v_q[0], 39))
       + ((v_q[0] & v_q[1]) ^ (v_q[0] & v_q[2]) ^ (v_q[1] & v_q[2]));
    // W_{t+16} from the sliding window
    w_new = (rotr(w_q[14], 19) ^ rotr(w_q[14], 61) ^ (w_q[14] >> 6)) + w_q[9]
          + (rotr(w_q[1], 1) ^ rotr(w_q[1], 8) ^ (w_q[1] >> 7)) + w_q[0];
  end

  // Commands only taken while idle
  assign start = (state_q == st_idle) && (ctrl.cmd != cmd_none) && !ctrl.zeroize;

  // --------------------
  // FSM: idle, load, 80 rounds, finalize
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= st_idle;
      round_q <= '0;
      valid_q <= 1'b0;
    end else if (ctrl.zeroize) begin
      state_q <= st_idle;
      round_q <= '0;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            state_q <= st_load;
            valid_q <= 1'b0;
          end
        end
        st_load: begin
          state_q <= st_rounds;
          round_q <= '0;
        end
        st_rounds: begin
          round_q <= round_q + 7'd1;
          if (round_q == last_round) state_q <= st_finalize;
        end
        st_finalize: begin
          state_q <= st_idle;
          valid_q <= 1'b1;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Hash, working variables and schedule window
  always_ff @(posedge clk) begin
    if (ctrl.zeroize) begin
      h_q <= '0;
      v_q <= '0;
      w_q <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          // NEXT keeps the chained hash
          if (start && ctrl.cmd == cmd_init) h_q <= iv;
        end
        st_load: begin
          v_q <= h_q;
          w_q <= block;
        end
        st_rounds: begin
          v_q <= {t1 + t2, v_q[0], v_q[1], v_q[2], v_q[3] + t1, v_q[4], v_q[5], v_q[6]};
          w_q <= {w_q[1:15], w_new};
        end
        st_finalize: begin
          for (int i = 0; i < 8; i++) h_q[i] <= h_q[i] + v_q[i];
        end
        default: ;
      endcase
    end
  end

  assign status.ready        = (state_q == st_idle);
  assign status.digest_valid = valid_q;
  assign digest              = h_q;

endmodule

/* rtl/sha512_core_pkg.sv */
package sha512_core_pkg;

  // Encoding follows the CTRL.MODE field
  typedef enum logic [1:0] {
    mode_224 = 2'd0,
    mode_256 = 2'd1,
    mode_384 = 2'd2,
    mode_512 = 2'd3
  } sha512_mode_e;

  // One-cycle command to the core
  typedef enum logic [1:0] {
    cmd_none = 2'd0,
    cmd_init = 2'd1,
    cmd_next = 2'd2
  } sha512_cmd_e;

  typedef enum logic [1:0] {st_idle, st_load, st_rounds, st_finalize} sha512_state_e;

  typedef struct packed {
    logic ready;
    logic digest_valid;
  } sha512_status_t;

endpackage

/* rtl/sha512_k_rom.sv */
`timescale 1ns/1ns

module sha512_k_rom (
  input  logic [6:0]  round,
  output logic [63:0] k
);

  // FIPS 180-4 round constants K0..K79
  always_comb begin
    case (round)
      7'd0:  k = 64'h428a2f98d728ae22;
      7'd1:  k = 64'h7137449123ef65cd;
      7'd2:  k = 64'hb5c0fbcfec4d3b2f;
      7'd3:  k = 64'he9b5dba58189dbbc;
      7'd4:  k = 64'h3956c25bf348b538;
      7'd5:  k = 64'h59f111f1b605d019;
      7'd6:  k = 64'h923f82a4af194f9b;
      7'd7:  k = 64'hab1c5ed5da6d8118;
      7'd8:  k = 64'hd807aa98a3030242;
      7'd9:  k = 64'h12835b0145706fbe;
      7'd10: k = 64'h243185be4ee4b28c;
      7'd11: k = 64'h550c7dc3d5ffb4e2;
      7'd12: k = 64'h72be5d74f27b896f;
      7'd13: k = 64'h80deb1fe3b1696b1;
      7'd14: k = 64'h9bdc06a725c71235;
      7'd15: k = 64'hc19bf174cf692694;
      7'd16: k = 64'he49b69c19ef14ad2;
      7'd17: k = 64'hefbe4786384f25e3;
      7'd18: k = 64'h0fc19dc68b8cd5b5;
      7'd19: k = 64'h240ca1cc77ac9c65;
      7'd20: k = 64'h2de92c6f592b0275;
      7'd21: k = 64'h4a7484aa6ea6e483;
      7'd22: k = 64'h5cb0a9dcbd41fbd4;
      7'd23: k = 64'h76f988da831153b5;
      7'd24: k = 64'h983e5152ee66dfab;
      7'd25: k = 64'ha831c66d2db43210;
      7'd26: k = 64'hb00327c898fb213f;
      7'd27: k = 64'hbf597fc7beef0ee4;
      7'd28: k = 64'hc6e00bf33da88fc2;
      7'd29: k = 64'hd5a79147930aa725;
      7'd30: k = 64'h06ca6351e003826f;
      7'd31: k = 64'h142929670a0e6e70;
      7'd32: k = 64'h27b70a8546d22ffc;
      7'd33: k = 64'h2e1b21385c26c926;
      7'd34: k = 64'h4d2c6dfc5ac42aed;
      7'd35: k = 64'h53380d139d95b3df;
      7'd36: k = 64'h650a73548baf63de;
      7'd37: k = 64'h766a0abb3c77b2a8;
      7'd38: k = 64'h81c2c92e47edaee6;
      7'd39: k = 64'h92722c851482353b;
      7'd40: k = 64'ha2bfe8a14cf10364;
      7'd41: k = 64'ha81a664bbc423001;
      7'd42: k = 64'hc24b8b70d0f89791;
      7'd43: k = 64'hc76c51a30654be30;
      7'd44: k = 64'hd192e819d6ef5218;
      7'd45: k = 64'hd69906245565a910;
      7'd46: k = 64'hf40e35855771202a;
      7'd47: k = 64'h106aa07032bbd1b8;
      7'd48: k = 64'h19a4c116b8d2d0c8;
      7'd49: k = 64'h1e376c085141ab53;
      7'd50: k = 64'h2748774cdf8eeb99;
      7'd51: k = 64'h34b0bcb5e19b48a8;
      7'd52: k = 64'h391c0cb3c5c95a63;
      7'd53: k = 64'h4ed8aa4ae3418acb;
      7'd54: k = 64'h5b9cca4f7763e373;
      7'd55: k = 64'h682e6ff3d6b2b8a3;
      7'd56: k = 64'h748f82ee5defb2fc;
      7'd57: k = 64'h78a5636f43172f60;
      7'd58: k = 64'h84c87814a1f0ab72;
      7'd59: k = 64'h8cc702081a6439ec;
      7'd60: k = 64'h90befffa23631e28;
      7'd61: k = 64'ha4506cebde82bde9;
      7'd62: k = 64'hbef9a3f7b2c67915;
      7'd63: k = 64'hc67178f2e372532b;
      7'd64: k = 64'hca273eceea26619c;
      7'd65: k = 64'hd186b8c721c0c207;
      7'd66: k = 64'heada7dd6cde0eb1e;
      7'd67: k = 64'hf57d4f7fee6ed178;
      7'd68: k = 64'h06f067aa72176fba;
      7'd69: k = 64'h0a637dc5a2c898a6;
      7'd70: k = 64'h113f9804bef90dae;
      7'd71: k = 64'h1b710b35131c471b;
      7'd72: k = 64'h28db77f523047d84;
      7'd73: k = 64'h32caab7b40c72493;
      7'd74: k = 64'h3c9ebe0a15c9bebc;
      7'd75: k = 64'h431d67c49c100d4c;
      7'd76: k = 64'h4cc5d4becb3e42b6;
      7'd77: k = 64'h597f299cfc657e2a;
      7'd78: k = 64'h5fcb6fab3ad6faec;
      7'd79: k = 64'h6c44198c4a475817;
      // Rounds past 79 never index here
      default: k = 64'h0;
    endcase
  end

endmodule

/* rtl/sha512_reg_pkg.sv */
package sha512_reg_pkg;

  `include "sha512_params.svh"

  // Wishbone classic request from the master
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`SHA512_ADDR_W-1:0] adr;
    logic [`SHA512_DATA_W-1:0] dat;
  } wb_req_t;

  // Slave response, one-cycle ack or err
  typedef struct packed {
    logic [`SHA512_DATA_W-1:0] dat;
    logic                      ack;
    logic                      err;
  } wb_rsp_t;

  // Decoded CTRL fields as seen by the core
  typedef struct packed {
    logic                         zeroize;
    sha512_core_pkg::sha512_mode_e mode;
    sha512_core_pkg::sha512_cmd_e  cmd;
  } sha512_ctrl_t;

  // Single registers plus the base of each window
  typedef enum logic [`SHA512_ADDR_W-1:0] {
    addr_name     = `SHA512_ADDR_NAME,
    addr_ctrl     = `SHA512_ADDR_CTRL,
    addr_status   = `SHA512_ADDR_STATUS,
    addr_intr_sts = `SHA512_ADDR_INTR_STS,
    addr_intr_en  = `SHA512_ADDR_INTR_EN,
    addr_block    = `SHA512_ADDR_BLOCK,
    addr_digest   = `SHA512_ADDR_DIGEST
  } sha512_addr_e;

endpackage

/* rtl/sha512_regs.sv */
`timescale 1ns/1ns

module sha512_regs (
  input  logic                            clk,
  input  logic                            reset_n,
  input  sha512_reg_pkg::wb_req_t          wb_req,
  output sha512_reg_pkg::wb_rsp_t          wb_rsp,
  output sha512_reg_pkg::sha512_ctrl_t     ctrl,
  output logic [1023:0]                   block,
  input  sha512_core_pkg::sha512_status_t  status,
  input  logic [511:0]                    digest,
  output logic                            notif_intr
);
  import sha512_reg_pkg::*;
  import sha512_core_pkg::*;
  `include "sha512_params.svh"

  localparam logic [`SHA512_ADDR_W-1:0] blk_base = addr_block;
  localparam logic [`SHA512_ADDR_W-1:0] dig_base = addr_digest;

  wb_rsp_t                   rsp_q;
  sha512_ctrl_t              ctrl_q;
  logic [0:31][31:0]         blk_q;
  logic [0:15][31:0]         digest_q;
  logic [0:15][31:0]         dig_w;
  logic                      valid_q;
  logic                      intr_sts_q;
  logic                      intr_en_q;
  logic                      acc;
  logic                      wr_en;
  logic                      mapped;
  logic                      ro;
  logic                      dec_ok;
  logic                      rise;
  logic [4:0]                n_words;
  logic [`SHA512_DATA_W-1:0] rd_word;

  // --------------------
  // Address decode
  always_comb begin
    rd_word = '0;
    mapped  = 1'b1;
    ro      = 1'b0;
    case (wb_req.adr)
      addr_name: begin
        rd_word = `SHA512_CORE_NAME;
        ro      = 1'b1;
      end
      addr_ctrl:     rd_word = {27'b0, ctrl_q.zeroize, ctrl_q.mode, 2'b00};
      addr_status: begin
        rd_word = {30'b0, valid_q, status.ready};
        ro      = 1'b1;
      end
      addr_intr_sts: rd_word = {31'b0, intr_sts_q};
      addr_intr_en:  rd_word = {31'b0, intr_en_q};
      default: begin
        if (wb_req.adr[7:5] == blk_base[7:5]) begin
          rd_word = blk_q[wb_req.adr[4:0]];
        end else if (wb_req.adr[7:4] == dig_base[7:4]) begin
          rd_word = digest_q[wb_req.adr[3:0]];
          ro      = 1'b1;
        end else begin
          mapped = 1'b0;
        end
      end
    endcase
    // Writes to read-only registers fail
    dec_ok = mapped & ~(wb_req.we & ro);
  end

  // New access only while no response is pending
  assign acc   = wb_req.cyc & wb_req.stb & ~rsp_q.ack & ~rsp_q.err;
  assign wr_en = acc & wb_req.we & dec_ok;
  assign rise  = status.digest_valid & ~valid_q;
  assign dig_w = digest;

  // Digest words kept per mode
  always_comb begin
    case (ctrl_q.mode)
      mode_224: n_words = 5'd7;
      mode_256: n_words = 5'd8;
      mode_384: n_words = 5'd12;
      default:  n_words = 5'd16;
    endcase
  end

  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rsp_q      <= '0;
      ctrl_q     <= '{zeroize: 1'b0, mode: mode_512, cmd: cmd_none};
      valid_q    <= 1'b0;
      intr_sts_q <= 1'b0;
      intr_en_q  <= 1'b0;
      digest_q   <= '0;
    end else begin
      // Response one clock after the request
      rsp_q.ack <= acc & dec_ok;
      rsp_q.err <= acc & ~dec_ok;
      rsp_q.dat <= (acc & dec_ok & ~wb_req.we) ? rd_word : '0;
      valid_q   <= status.digest_valid;
      // Command is a single-cycle pulse
      ctrl_q.cmd <= cmd_none;
      if (wr_en && wb_req.adr == addr_ctrl) begin
        ctrl_q.zeroize <= wb_req.dat[4];
        ctrl_q.mode    <= sha512_mode_e'(wb_req.dat[3:2]);
        // INIT wins when both are set
        if (wb_req.dat[0]) ctrl_q.cmd <= cmd_init;
        else if (wb_req.dat[1]) ctrl_q.cmd <= cmd_next;
      end
      if (wr_en && wb_req.adr == addr_intr_en) intr_en_q <= wb_req.dat[0];
      // Set beats write-one-to-clear
      if (rise) intr_sts_q <= 1'b1;
      else if (wr_en && wb_req.adr == addr_intr_sts && wb_req.dat[0]) intr_sts_q <= 1'b0;
      if (ctrl_q.zeroize) begin
        digest_q <= '0;
      end else if (rise) begin
        for (int i = 0; i < 16; i++) digest_q[i] <= (i < n_words) ? dig_w[i] : 32'h0;
      end
    end
  end

  // Block words, word 0 lands in the top bits
  always_ff @(posedge clk) begin
    if (ctrl_q.zeroize) blk_q <= '0;
    else if (wr_en && wb_req.adr[7:5] == blk_base[7:5]) blk_q[wb_req.adr[4:0]] <= wb_req.dat;
  end

  assign block      = blk_q;
  assign ctrl       = ctrl_q;
  assign wb_rsp     = rsp_q;
  assign notif_intr = intr_sts_q & intr_en_q;

endmodule

/* sim.f */
+incdir+include
rtl/sha512_core_pkg.sv
rtl/sha512_reg_pkg.sv
rtl/sha512_k_rom.sv
rtl/sha512_core.sv
rtl/sha512_regs.sv
rtl/sha512.sv
tb/tb_sha512.sv

/* tb/tb_sha512.sv */
`timescale 1ns/1ns

module tb_sha512;
  import sha512_reg_pkg::*;
  import sha512_core_pkg::*;
  `include "sha512_params.svh"

  // --------------------
  // Published digests left aligned in 512 bits
  // Words past the mode length are zero
  localparam logic [511:0] abc_512 = {
    64'hddaf35a193617aba, 64'hcc417349ae204131, 64'h12e6fa4e89a97ea2, 64'h0a9eeee64b55d39a,
    64'h2192992a274fc1a8, 64'h36ba3c23a3feebbd, 64'h454d4423643ce80e, 64'h2a9ac94fa54ca49f};
  localparam logic [511:0] abc_384 = {
    64'hcb00753f45a35e8b, 64'hb5a03d699ac65007, 64'h272c32ab0eded163, 64'h1a8b605a43ff5bed,
    64'h8086072ba1e7cc23, 64'h58baeca134c825a7, 128'h0};
  localparam logic [511:0] abc_256 = {
    64'h53048e2681941ef9, 64'h9b2e29b76b4c7dab, 64'he4c2d0c634fc6d46, 64'he0e2f13107e7af23,
    256'h0};
  localparam logic [511:0] abc_224 = {
    64'h4634270f707b6a54, 64'hdaae7530460842e2, 64'h0e37ed265ceee9a4, 32'h3e8924aa, 288'h0};
  // 896-bit two-block message
  localparam logic [511:0] two_blk_512 = {
    64'h8e959b75dae313da, 64'h8cf4f72814fc143f, 64'h8f7779c6eb9f7fa1, 64'h7299aeadb6889018,
    64'h501d289e4900f7e4, 64'h331b99dec4b5433a, 64'hc7d329eeb6dd2654, 64'h5e96e55b874be909};

  localparam wb_rsp_t rsp_ack = '{dat: '0, ack: 1'b1, err: 1'b0};
  localparam wb_rsp_t rsp_err = '{dat: '0, ack: 1'b0, err: 1'b1};

  logic        clk;
  logic        reset_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        notif_intr;
  int          errors;
  int          checks;
  logic [31:0] rng_state;

  sha512 DUT (
    .clk        (clk),
    .reset_n    (reset_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .notif_intr (notif_intr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Compare tasks
  task automatic check_word(input string what, input logic [`SHA512_DATA_W-1:0] got,
                            input logic [`SHA512_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Only ack and err matter here
  task automatic check_rsp(input string what, input wb_rsp_t got, input wb_rsp_t exp);
    checks++;
    if (got.ack !== exp.ack || got.err !== exp.err) begin
      errors++;
      $display("[ERROR] %0t: %s ack/err %b/%b expected %b/%b", $time, what,
               got.ack, got.err, exp.ack, exp.err);
    end
  endtask

  task automatic check_intr(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s notif_intr %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // --------------------
  // Wishbone master
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           output wb_rsp_t rsp);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    // Response sampled mid-cycle
    while (!done && cycles < 16) begin
      @(negedge clk);
      cycles++;
      done = wb_rsp.ack | wb_rsp.err;
    end
    rsp = wb_rsp;
    @(posedge clk);
    wb_req <= '0;
    if (!done) stop_on_timeout("a bus response");
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    wb_rsp_t rsp;
    bus_cycle(1'b1, adr, dat, rsp);
    check_rsp($sformatf("write 0x%h", adr), rsp, rsp_ack);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
    wb_rsp_t rsp;
    bus_cycle(1'b0, adr, 32'h0, rsp);
    check_rsp($sformatf("read 0x%h", adr), rsp, rsp_ack);
    data = rsp.dat;
  endtask

  // Poll STATUS bit 1 until set
  task automatic wait_valid();
    logic [31:0] sts;
    int          polls;
    polls = 0;
    sts   = '0;
    while (!sts[1] && polls < 100) begin
      wb_read(`SHA512_ADDR_STATUS, sts);
      polls++;
    end
    if (!sts[1]) stop_on_timeout("STATUS.valid");
  endtask

  // --------------------
  // Stimulus helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // CTRL bit 4 zeroize, bits 3:2 mode, bit 1 next, bit 0 init
  function automatic logic [31:0] ctrl_word(input logic zeroize, input sha512_mode_e mode,
                                            input sha512_cmd_e cmd);
    return {27'b0, zeroize, mode, cmd == cmd_next, cmd == cmd_init};
  endfunction

  // "abc" with padding and a 24-bit length
  function automatic logic [0:31][31:0] abc_block();
    logic [0:31][31:0] blk;
    blk     = '0;
    blk[0]  = 32'h61626380;
    blk[31] = 32'd24;
    return blk;
  endfunction

  // First block of "abcdefgh bcdefghi ... nopqrstu" plus the pad bit
  function automatic logic [0:31][31:0] msg2_first();
    logic [0:31][31:0] blk;
    logic [7:0]        c;
    blk = '0;
    for (int i = 0; i < 28; i++) begin
      c      = 8'h61 + 8'(i / 2) + 8'(4 * (i % 2));
      blk[i] = {c, c + 8'd1, c + 8'd2, c + 8'd3};
    end
    blk[28] = 32'h80000000;
    return blk;
  endfunction

  task automatic hash_block(input logic [0:31][31:0] words, input sha512_mode_e mode,
                            input sha512_cmd_e cmd);
    for (int i = 0; i < 32; i++) wb_write(8'(`SHA512_ADDR_BLOCK + i), words[i]);
    wb_write(`SHA512_ADDR_CTRL, ctrl_word(1'b0, mode, cmd));
    wait_valid();
  endtask

  task automatic check_digest(input string what, input logic [511:0] exp);
    logic [31:0] d;
    for (int i = 0; i < 16; i++) begin
      wb_read(8'(`SHA512_ADDR_DIGEST + i), d);
      check_word($sformatf("%s word %0d", what, i), d, exp[511 - 32 * i -: 32]);
    end
  endtask

  // --------------------
  // Directed tests
  task automatic probe_register_map();
    logic [31:0] d;
    wb_rsp_t     rsp;
    // Idle core is ready with no digest yet
    wb_read(`SHA512_ADDR_STATUS, d);
    check_word("STATUS after reset", d, 32'h1);
    wb_read(`SHA512_ADDR_NAME, d);
    check_word("NAME", d, `SHA512_CORE_NAME);
    bus_cycle(1'b0, 8'h10, 32'h0, rsp);
    check_rsp("read unmapped 0x10", rsp, rsp_err);
    // STATUS is read-only
    bus_cycle(1'b1, `SHA512_ADDR_STATUS, 32'h3, rsp);
    check_rsp("write STATUS", rsp, rsp_err);
  endtask

  task automatic digest_abc_per_mode();
    hash_block(abc_block(), mode_512, cmd_init);
    check_digest("SHA-512 abc", abc_512);
    hash_block(abc_block(), mode_384, cmd_init);
    check_digest("SHA-384 abc", abc_384);
    hash_block(abc_block(), mode_256, cmd_init);
    check_digest("SHA-512/256 abc", abc_256);
    hash_block(abc_block(), mode_224, cmd_init);
    check_digest("SHA-512/224 abc", abc_224);
  endtask

  task automatic chain_two_blocks();
    logic [0:31][31:0] last;
    last     = '0;
    last[31] = 32'd896;
    hash_block(msg2_first(), mode_512, cmd_init);
    // NEXT has to chain from block 1
    hash_block(last, mode_512, cmd_next);
    check_digest("SHA-512 two-block", two_blk_512);
  endtask

  task automatic exercise_interrupt();
    wb_write(`SHA512_ADDR_INTR_STS, 32'h1);
    wb_write(`SHA512_ADDR_INTR_EN, 32'h1);
    @(negedge clk);
    check_intr("enabled, before hash", notif_intr, 1'b0);
    hash_block(abc_block(), mode_512, cmd_init);
    @(negedge clk);
    check_intr("enabled, after valid", notif_intr, 1'b1);
    wb_write(`SHA512_ADDR_INTR_STS, 32'h1);
    @(negedge clk);
    check_intr("after W1C", notif_intr, 1'b0);
    wb_write(`SHA512_ADDR_INTR_EN, 32'h0);
    hash_block(abc_block(), mode_512, cmd_init);
    @(negedge clk);
    check_intr("disabled, after valid", notif_intr, 1'b0);
  endtask

  task automatic readback_then_zeroize();
    logic [0:31][31:0] blk;
    logic [31:0]       d;
    for (int i = 0; i < 32; i++) begin
      rng_state = xorshift(rng_state);
      blk[i]    = rng_state;
      wb_write(8'(`SHA512_ADDR_BLOCK + i), blk[i]);
    end
    for (int i = 0; i < 32; i++) begin
      wb_read(8'(`SHA512_ADDR_BLOCK + i), d);
      check_word($sformatf("block word %0d", i), d, blk[i]);
    end
    wb_write(`SHA512_ADDR_CTRL, ctrl_word(1'b1, mode_512, cmd_none));
    for (int i = 0; i < 32; i++) begin
      wb_read(8'(`SHA512_ADDR_BLOCK + i), d);
      check_word($sformatf("zeroized block word %0d", i), d, 32'h0);
    end
    check_digest("zeroized digest", 512'h0);
    wb_read(`SHA512_ADDR_STATUS, d);
    check_word("STATUS.valid after zeroize", {31'b0, d[1]}, 32'h0);
    // Release zeroize
    wb_write(`SHA512_ADDR_CTRL, ctrl_word(1'b0, mode_512, cmd_none));
  endtask

  // --------------------
  initial begin
    errors    = 0;
    checks    = 0;
    rng_state = 32'h1af9;
    wb_req    = '0;
    reset_n   = 1'b0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_intr("after reset", notif_intr, 1'b0);
    probe_register_map();
    digest_abc_per_mode();
    chain_two_blocks();
    exercise_interrupt();
    readback_then_zeroize();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
